// ==== verilog/noc_pkg.sv ====
// topology constants and port directions shared by the Spidergon routers and the top level
`default_nettype none

package noc_pkg;

	// number of routers on the ring, must be a multiple of four
	localparam int NUM_NODES = 8;

	// bits needed to name one node
	localparam int NODE_ID_WIDTH = $clog2(NUM_NODES);

	// local, clockwise, anticlockwise and across
	localparam int NUM_PORTS = 4;

	// ring distances up to this value stay on the ring
	// anything further away takes the across link first
	localparam int QUARTER = NUM_NODES / 4;

	// router port index, also used as the output selector of a route
	typedef enum logic [1:0] {
		dir_local         = 2'd0,
		dir_clockwise     = 2'd1,
		dir_anticlockwise = 2'd2,
		dir_across        = 2'd3
	} port_dir_e;

endpackage

`default_nettype wire

// ==== verilog/flit_pkg.sv ====
// flit format carried on every link and on the inject and eject ports of the network
`default_nettype none

package flit_pkg;

	// payload bits carried by each flit
	localparam int PAYLOAD_WIDTH = 16;

	// two-bit flit type code
	// only header flits are routed, the rest are dropped at the input
	typedef enum logic [1:0] {
		flit_tail   = 2'b00,
		flit_head   = 2'b01,
		flit_body   = 2'b10,
		flit_header = 2'b11
	} flit_type_e;

	// one single-flit packet
	typedef struct packed {
		flit_type_e                        flit_type;
		logic [noc_pkg::NODE_ID_WIDTH-1:0] dest;
		logic [noc_pkg::NODE_ID_WIDTH-1:0] src;
		logic [PAYLOAD_WIDTH-1:0]          payload;
	} flit_t;

endpackage

`default_nettype wire

// ==== verilog/input_port.sv ====
// router input buffer with the shortest-path, across-first route choice for its head flit
`timescale 1ns/1ps
`default_nettype none

module input_port #(
	parameter int FIFO_DEPTH = 2,
	parameter int NODE_ID = 0
) (
	input  logic                           clk,
	input  logic                           reset,
	input  flit_pkg::flit_t                in_flit,
	input  logic                           in_valid,
	output logic                           in_ready,
	input  logic                           grant,
	output logic [noc_pkg::NUM_PORTS-1:0]  request,
	output flit_pkg::flit_t                head_flit
);
	import noc_pkg::*;
	import flit_pkg::*;

	localparam int PTR_WIDTH = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int COUNT_WIDTH = $clog2(FIFO_DEPTH + 1);
	localparam int DIST_WIDTH = NODE_ID_WIDTH + 1;
	localparam logic [DIST_WIDTH-1:0] NODES_D = DIST_WIDTH'(NUM_NODES);
	localparam logic [DIST_WIDTH-1:0] OFFSET_D = DIST_WIDTH'(NUM_NODES - NODE_ID);
	localparam logic [DIST_WIDTH-1:0] QUARTER_D = DIST_WIDTH'(QUARTER);
	localparam logic [DIST_WIDTH-1:0] FAR_D = DIST_WIDTH'(NUM_NODES - QUARTER);

	flit_t                  fifo_mem [FIFO_DEPTH];
	logic [PTR_WIDTH-1:0]   rd_ptr;
	logic [PTR_WIDTH-1:0]   wr_ptr;
	logic [COUNT_WIDTH-1:0] count;
	logic                   fifo_empty;
	logic                   push;
	logic                   pop;
	logic                   drop;
	logic [DIST_WIDTH-1:0]  sum;
	logic [DIST_WIDTH-1:0]  distance;
	port_dir_e              route_dir;

	function automatic logic [PTR_WIDTH-1:0] next_ptr(input logic [PTR_WIDTH-1:0] ptr);
		if (ptr == PTR_WIDTH'(FIFO_DEPTH - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	assign fifo_empty = (count == '0);
	assign in_ready = (count != COUNT_WIDTH'(FIFO_DEPTH));
	assign push = in_valid && in_ready;
	assign head_flit = fifo_mem[rd_ptr];
	// anything other than a header flit is discarded from the head
	assign drop = !fifo_empty && (head_flit.flit_type != flit_header);
	assign pop = grant || drop;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (push)
				wr_ptr <= next_ptr(wr_ptr);
			if (pop)
				rd_ptr <= next_ptr(rd_ptr);
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (push)
			fifo_mem[wr_ptr] <= in_flit;
	end

	// ring distance from this node to the destination, going clockwise
	always_comb
	begin
		sum = {1'b0, head_flit.dest} + OFFSET_D;
		distance = (sum >= NODES_D) ? sum - NODES_D : sum;
		if (distance == '0)
			route_dir = dir_local;
		else if (distance <= QUARTER_D)
			route_dir = dir_clockwise;
		else if (distance >= FAR_D)
			route_dir = dir_anticlockwise;
		else
			route_dir = dir_across;
	end

	always_comb
	begin
		request = '0;
		if (!fifo_empty && !drop)
			request[route_dir] = 1'b1;
	end

endmodule

`default_nettype wire

// ==== verilog/output_arbiter.sv ====
// round-robin arbiter and output register for one outgoing link of a router
`timescale 1ns/1ps
`default_nettype none

module output_arbiter (
	input  logic                                   clk,
	input  logic                                   reset,
	input  logic [noc_pkg::NUM_PORTS-1:0]          request,
	output logic [noc_pkg::NUM_PORTS-1:0]          grant,
	input  flit_pkg::flit_t [noc_pkg::NUM_PORTS-1:0] in_flit,
	output flit_pkg::flit_t                        out_flit,
	output logic                                   out_valid,
	input  logic                                   out_ready
);
	import noc_pkg::*;
	import flit_pkg::*;

	localparam int SEL_WIDTH = $clog2(NUM_PORTS);

	logic [SEL_WIDTH-1:0] last;
	logic [SEL_WIDTH-1:0] winner;
	logic [SEL_WIDTH-1:0] idx;
	logic                 any_request;
	logic                 can_load;

	// the register may take a new flit when empty or when it drains this cycle
	assign can_load = !out_valid || out_ready;

	// search starts one past the previous winner
	always_comb
	begin
		winner = last;
		any_request = 1'b0;
		idx = last;
		for (int i = 1; i <= NUM_PORTS; i++)
		begin
			idx = last + SEL_WIDTH'(i);
			if (!any_request && request[idx])
			begin
				any_request = 1'b1;
				winner = idx;
			end
		end
		grant = '0;
		if (any_request && can_load)
			grant[winner] = 1'b1;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			out_valid <= 1'b0;
			last <= '0;
		end
		else if (|grant)
		begin
			out_valid <= 1'b1;
			last <= winner;
		end
		else if (out_ready)
			out_valid <= 1'b0;
	end

	always_ff @(posedge clk)
	begin
		if (|grant)
			out_flit <= in_flit[winner];
	end

endmodule

`default_nettype wire

// ==== verilog/spidergon_router.sv ====
// one Spidergon node: four buffered inputs switched onto four arbitrated outputs
`timescale 1ns/1ps
`default_nettype none

module spidergon_router #(
	parameter int FIFO_DEPTH = 2,
	parameter int NODE_ID = 0
) (
	input  logic                                     clk,
	input  logic                                     reset,
	input  flit_pkg::flit_t [noc_pkg::NUM_PORTS-1:0] link_in_flit,
	input  logic [noc_pkg::NUM_PORTS-1:0]            link_in_valid,
	output logic [noc_pkg::NUM_PORTS-1:0]            link_in_ready,
	output flit_pkg::flit_t [noc_pkg::NUM_PORTS-1:0] link_out_flit,
	output logic [noc_pkg::NUM_PORTS-1:0]            link_out_valid,
	input  logic [noc_pkg::NUM_PORTS-1:0]            link_out_ready
);
	import noc_pkg::*;
	import flit_pkg::*;

	// requests as raised by each input, [input][output]
	logic [NUM_PORTS-1:0][NUM_PORTS-1:0] input_request;
	// requests as seen by each arbiter, [output][input]
	logic [NUM_PORTS-1:0][NUM_PORTS-1:0] arbiter_request;
	// grants from each arbiter, [output][input]
	logic [NUM_PORTS-1:0][NUM_PORTS-1:0] arbiter_grant;
	// grants regrouped per input, [input][output]
	logic [NUM_PORTS-1:0][NUM_PORTS-1:0] input_grant;
	flit_t [NUM_PORTS-1:0]               head_flit;

	// crossbar request and grant transpose
	for (genvar o = 0; o < NUM_PORTS; o++)
	begin : g_xbar_out
		for (genvar i = 0; i < NUM_PORTS; i++)
		begin : g_xbar_in
			assign arbiter_request[o][i] = input_request[i][o];
			assign input_grant[i][o] = arbiter_grant[o][i];
		end
	end

	for (genvar p = 0; p < NUM_PORTS; p++)
	begin : g_port
		input_port #(
			.FIFO_DEPTH (FIFO_DEPTH),
			.NODE_ID    (NODE_ID)
		) input_port_i (
			.clk       (clk),
			.reset     (reset),
			.in_flit   (link_in_flit[p]),
			.in_valid  (link_in_valid[p]),
			.in_ready  (link_in_ready[p]),
			// an input requests one output, so at most one grant bit is set
			.grant     (|input_grant[p]),
			.request   (input_request[p]),
			.head_flit (head_flit[p])
		);

		output_arbiter output_arbiter_i (
			.clk       (clk),
			.reset     (reset),
			.request   (arbiter_request[p]),
			.grant     (arbiter_grant[p]),
			.in_flit   (head_flit),
			.out_flit  (link_out_flit[p]),
			.out_valid (link_out_valid[p]),
			.out_ready (link_out_ready[p])
		);
	end

endmodule

`default_nettype wire

// ==== verilog/spidergon_top.sv ====
// eight-node Spidergon network with per-node inject and eject ports, top of the design
`timescale 1ns/1ps
`default_nettype none

module spidergon_top #(
	parameter int FIFO_DEPTH = 2
) (
	input  logic                                     clk,
	input  logic                                     reset,
	input  flit_pkg::flit_t [noc_pkg::NUM_NODES-1:0] inject_flit,
	input  logic [noc_pkg::NUM_NODES-1:0]            inject_valid,
	output logic [noc_pkg::NUM_NODES-1:0]            inject_ready,
	output flit_pkg::flit_t [noc_pkg::NUM_NODES-1:0] eject_flit,
	output logic [noc_pkg::NUM_NODES-1:0]            eject_valid
);
	import noc_pkg::*;
	import flit_pkg::*;

	localparam int HALF = NUM_NODES / 2;

	flit_t [NUM_NODES-1:0][NUM_PORTS-1:0] in_flit;
	flit_t [NUM_NODES-1:0][NUM_PORTS-1:0] out_flit;
	logic  [NUM_NODES-1:0][NUM_PORTS-1:0] in_valid;
	logic  [NUM_NODES-1:0][NUM_PORTS-1:0] in_ready;
	logic  [NUM_NODES-1:0][NUM_PORTS-1:0] out_valid;
	logic  [NUM_NODES-1:0][NUM_PORTS-1:0] out_ready;

	for (genvar n = 0; n < NUM_NODES; n++)
	begin : g_node
		localparam int NEXT = (n + 1) % NUM_NODES;
		localparam int PREV = (n + NUM_NODES - 1) % NUM_NODES;
		localparam int OPP = (n + HALF) % NUM_NODES;

		// local pair is the inject and eject port, eject never stalls
		assign in_flit[n][dir_local] = inject_flit[n];
		assign in_valid[n][dir_local] = inject_valid[n];
		assign inject_ready[n] = in_ready[n][dir_local];
		assign eject_flit[n] = out_flit[n][dir_local];
		assign eject_valid[n] = out_valid[n][dir_local];
		assign out_ready[n][dir_local] = 1'b1;

		// clockwise output of a node enters the anticlockwise input of the next
		assign in_flit[n][dir_anticlockwise] = out_flit[PREV][dir_clockwise];
		assign in_valid[n][dir_anticlockwise] = out_valid[PREV][dir_clockwise];
		assign out_ready[n][dir_clockwise] = in_ready[NEXT][dir_anticlockwise];

		assign in_flit[n][dir_clockwise] = out_flit[NEXT][dir_anticlockwise];
		assign in_valid[n][dir_clockwise] = out_valid[NEXT][dir_anticlockwise];
		assign out_ready[n][dir_anticlockwise] = in_ready[PREV][dir_clockwise];

		// across link pairs each node with the one half a ring away
		assign in_flit[n][dir_across] = out_flit[OPP][dir_across];
		assign in_valid[n][dir_across] = out_valid[OPP][dir_across];
		assign out_ready[n][dir_across] = in_ready[OPP][dir_across];

		spidergon_router #(
			.FIFO_DEPTH (FIFO_DEPTH),
			.NODE_ID    (n)
		) router_i (
			.clk            (clk),
			.reset          (reset),
			.link_in_flit   (in_flit[n]),
			.link_in_valid  (in_valid[n]),
			.link_in_ready  (in_ready[n]),
			.link_out_flit  (out_flit[n]),
			.link_out_valid (out_valid[n]),
			.link_out_ready (out_ready[n])
		);
	end

endmodule

`default_nettype wire

// ==== bench/spidergon_checker.sv ====
// bound assertions on the Spidergon top-level ports, attached to spidergon_top by the bind below
`timescale 1ns/1ps
`default_nettype none

module spidergon_checker (
	input logic                                     clk,
	input logic                                     reset,
	input flit_pkg::flit_t [noc_pkg::NUM_NODES-1:0] inject_flit,
	input logic [noc_pkg::NUM_NODES-1:0]            inject_valid,
	input logic [noc_pkg::NUM_NODES-1:0]            inject_ready,
	input flit_pkg::flit_t [noc_pkg::NUM_NODES-1:0] eject_flit,
	input logic [noc_pkg::NUM_NODES-1:0]            eject_valid
);
	import noc_pkg::*;
	import flit_pkg::*;

	int unsigned          fail_count = 0;
	int                   in_flight;
	logic [NUM_NODES-1:0] accept;
	logic [NUM_NODES-1:0] accept_header;
	logic [NUM_NODES-1:0] self_idle;

	assign accept = inject_valid & inject_ready;

	// flits accepted but not yet ejected, counted at the ports only
	always_ff @(posedge clk)
	begin
		if (reset)
			in_flight <= 0;
		else
			in_flight <= in_flight + $countones(accept_header) - $countones(eject_valid);
	end

	// registers are cleared while reset is applied and stay idle for one cycle after
	a_reset_idle: assert property (@(posedge clk)
		$past(reset) |-> (eject_valid == '0 && inject_ready == '1))
		else
		begin
			fail_count++;
			$error("eject_valid high or inject_ready low around reset");
		end

	for (genvar n = 0; n < NUM_NODES; n++)
	begin : g_node
		// only header flits ever reach an eject port
		assign accept_header[n] = accept[n] && (inject_flit[n].flit_type == flit_header);
		assign self_idle[n] = accept_header[n] && (inject_flit[n].dest == NODE_ID_WIDTH'(n))
			&& (in_flight == 0);

		a_eject_addr: assert property (@(posedge clk) disable iff (reset)
			eject_valid[n] |-> (eject_flit[n].dest == NODE_ID_WIDTH'(n)
				&& eject_flit[n].flit_type == flit_header))
			else
			begin
				fail_count++;
				$error("node %0d ejected a flit that is not a header addressed to it", n);
			end

		// one cycle in the input FIFO, one in the eject register
		a_self_latency: assert property (@(posedge clk) disable iff (reset)
			$past(self_idle[n], 2) |-> (eject_valid[n] && !$past(eject_valid[n])))
			else
			begin
				fail_count++;
				$error("self-addressed flit at node %0d not ejected two cycles after accept", n);
			end
	end

endmodule

bind spidergon_top spidergon_checker checker_i (
	.clk          (clk),
	.reset        (reset),
	.inject_flit  (inject_flit),
	.inject_valid (inject_valid),
	.inject_ready (inject_ready),
	.eject_flit   (eject_flit),
	.eject_valid  (eject_valid)
);

`default_nettype wire

// ==== bench/spidergon_tb.sv ====
// testbench for the Spidergon network, runs random, hot-spot and self-addressed traffic
`timescale 1ns/1ps
`default_nettype none

module spidergon_tb;
	import noc_pkg::*;
	import flit_pkg::*;

	localparam int FIFO_DEPTH = 2;
	localparam int RANDOM_FLITS = 12;
	localparam int BURST_FLITS = 4;
	localparam int SELF_FLITS = 8;
	localparam int TOTAL_FLITS = NUM_NODES * (RANDOM_FLITS + BURST_FLITS + SELF_FLITS);
	localparam int HOT_NODE = 5;
	// about fifteen cycles per flit at worst, plus reset and drain
	localparam int TIMEOUT_CYCLES = TOTAL_FLITS * 15 + 120;

	logic                  clk = 1'b0;
	logic                  reset;
	flit_t [NUM_NODES-1:0] inject_flit;
	logic  [NUM_NODES-1:0] inject_valid;
	logic  [NUM_NODES-1:0] inject_ready;
	flit_t [NUM_NODES-1:0] eject_flit;
	logic  [NUM_NODES-1:0] eject_valid;

	logic [31:0]              rng_state = 32'd68;
	logic [NUM_NODES-1:0]     ready_seen = '0;
	logic [NUM_NODES-1:0]     stall_seen = '0;
	// expected payloads per source and destination pair, in send order
	logic [PAYLOAD_WIDTH-1:0] expected_q [NUM_NODES*NUM_NODES][$];
	int                       seq [NUM_NODES];
	int                       ejected [NUM_NODES];
	int                       accepted_total = 0;
	int                       ejected_total = 0;
	int                       error_count = 0;
	int                       cycle_count = 0;
	string                    test_name = "reset";

	spidergon_top #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) dut_i (
		.clk          (clk),
		.reset        (reset),
		.inject_flit  (inject_flit),
		.inject_valid (inject_valid),
		.inject_ready (inject_ready),
		.eject_flit   (eject_flit),
		.eject_valid  (eject_valid)
	);

	always #2 clk = ~clk;

	always @(posedge clk)
	begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES)
		begin
			$display("timeout after %0d cycles in %s, the network did not drain",
				cycle_count, test_name);
			$display("Test failed");
			$finish;
		end
	end

	// 32-bit LCG, upper half returned
	function automatic logic [15:0] next_random();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state[31:16];
	endfunction

	// payload is source, five random bits, then the sequence number
	function automatic flit_t make_flit(input int src, input int dest);
		flit_t       f;
		logic [15:0] r;
		r = next_random();
		f.flit_type = flit_header;
		f.dest = NODE_ID_WIDTH'(dest);
		f.src = NODE_ID_WIDTH'(src);
		f.payload = {NODE_ID_WIDTH'(src), r[4:0], 8'(seq[src])};
		return f;
	endfunction

	task automatic record_accept(input int node);
		int key;
		key = int'(inject_flit[node].src) * NUM_NODES + int'(inject_flit[node].dest);
		expected_q[key].push_back(inject_flit[node].payload);
		seq[node]++;
		accepted_total++;
	endtask

	task automatic check_eject(input int node, input flit_t flit);
		int                       key;
		logic [PAYLOAD_WIDTH-1:0] want;
		key = int'(flit.src) * NUM_NODES + node;
		ejected[node]++;
		ejected_total++;
		if (expected_q[key].size() == 0)
		begin
			error_count++;
			$display("unexpected flit from node %0d ejected at node %0d in %s",
				flit.src, node, test_name);
		end
		else
		begin
			want = expected_q[key].pop_front();
			if (flit.payload !== want)
			begin
				error_count++;
				$display("MISMATCH %s: payload %0d->%0d expected %h actual %h",
					test_name, flit.src, node, want, flit.payload);
			end
		end
	endtask

	// outputs are sampled mid-cycle, away from the edges
	always @(negedge clk)
	begin
		ready_seen = inject_ready;
		if (!reset && test_name == "burst")
			stall_seen = stall_seen | ~inject_ready;
		for (int n = 0; n < NUM_NODES; n++)
			if (eject_valid[n])
				check_eject(n, eject_flit[n]);
	end

	task automatic wait_idle();
		while (ejected_total != accepted_total)
			@(posedge clk);
	endtask

	task automatic run_traffic(input string name, input int count, input bit hot_spot);
		int left [NUM_NODES];
		int busy;
		test_name = name;
		for (int n = 0; n < NUM_NODES; n++)
			left[n] = count;
		do
		begin
			@(posedge clk);
			#1;
			busy = 0;
			for (int n = 0; n < NUM_NODES; n++)
			begin
				if (inject_valid[n] && ready_seen[n])
				begin
					// body flits are dropped at the input and never counted
					if (inject_flit[n].flit_type == flit_header)
					begin
						record_accept(n);
						left[n]--;
					end
					inject_valid[n] = 1'b0;
				end
				// random traffic idles about a third of the cycles
				if (!inject_valid[n] && left[n] > 0 && (hot_spot || next_random() % 3 != 0))
				begin
					inject_flit[n] = make_flit(n, hot_spot ? HOT_NODE : next_random() % NUM_NODES);
					// now and then a body flit, which the input port must discard
					if (!hot_spot && next_random() % 8 == 0)
						inject_flit[n].flit_type = flit_body;
					inject_valid[n] = 1'b1;
				end
				busy += left[n];
			end
		end
		while (busy > 0);
	endtask

	task automatic send_alone(input int node);
		@(posedge clk);
		#1;
		inject_flit[node] = make_flit(node, node);
		inject_valid[node] = 1'b1;
		do
		begin
			@(posedge clk);
			#1;
		end
		while (!ready_seen[node]);
		record_accept(node);
		inject_valid[node] = 1'b0;
		wait_idle();
	endtask

	task automatic check_final();
		test_name = "drain";
		for (int k = 0; k < NUM_NODES * NUM_NODES; k++)
		begin
			if (expected_q[k].size() != 0)
			begin
				error_count++;
				$display("%0d flits from node %0d to node %0d were never ejected",
					expected_q[k].size(), k / NUM_NODES, k % NUM_NODES);
			end
		end
		if (ejected_total != TOTAL_FLITS)
		begin
			error_count++;
			$display("MISMATCH %s: flits ejected expected %0d actual %0d",
				test_name, TOTAL_FLITS, ejected_total);
		end
		if (stall_seen == '0)
		begin
			error_count++;
			$display("inject_ready never went low during the hot-spot burst");
		end
		for (int n = 0; n < NUM_NODES; n++)
		begin
			if (ejected[n] == 0)
			begin
				error_count++;
				$display("node %0d never ejected a flit", n);
			end
		end
	endtask

	initial
	begin
		int assert_fails;
		reset = 1'b1;
		inject_valid = '0;
		inject_flit = '0;
		repeat (4) @(posedge clk);
		#1;
		reset = 1'b0;
		run_traffic("random", RANDOM_FLITS, 1'b0);
		wait_idle();
		run_traffic("burst", BURST_FLITS, 1'b1);
		wait_idle();
		test_name = "self";
		for (int r = 0; r < SELF_FLITS; r++)
			for (int n = 0; n < NUM_NODES; n++)
				send_alone(n);
		check_final();
		assert_fails = dut_i.checker_i.fail_count;
		$display("errors: scoreboard %0d, assertions %0d", error_count, assert_fails);
		if (error_count == 0 && assert_fails == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== files.f ====
verilog/noc_pkg.sv
verilog/flit_pkg.sv
verilog/input_port.sv
verilog/output_arbiter.sv
verilog/spidergon_router.sv
verilog/spidergon_top.sv
bench/spidergon_checker.sv
bench/spidergon_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP       = spidergon_tb
FILELIST  = files.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)
SIM_ARGS  = +verilator+error+limit+1000
SOURCES   = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM)
	@out="$$($(SIM) $(SIM_ARGS))"; echo "$$out"; echo "$$out" | grep -q "^Test passed$$"

clean:
	rm -rf $(OBJ_DIR)
